// File: logic/boot_reset_ctrl.sv
`default_nettype none

module boot_reset_ctrl (
	input  wire  clk_sd,
	input  wire  rst,
	input  wire  dl_active,
	input  wire  status_reset,
	input  wire  button_reset,
	output logic rom_loaded,
	output logic core_reset
);

	logic dl_active_q;
	logic dl_done;

	// End of a download
	assign dl_done = dl_active_q && !dl_active;

	always_ff @(posedge clk_sd) begin
		if (rst) begin
			dl_active_q <= 1'b0;
			rom_loaded  <= 1'b0;
		end else begin
			dl_active_q <= dl_active;
			if (dl_done) begin
				rom_loaded <= 1'b1;
			end
		end
	end

	// Core stays in reset until a full image has arrived
	always_ff @(posedge clk_sd) begin
		if (rst) begin
			core_reset <= 1'b1;
		end else begin
			core_reset <= status_reset || button_reset || !rom_loaded;
		end
	end

endmodule

`default_nettype wire

// File: logic/download_requester.sv
`default_nettype none

module download_requester import rom_load_pkg::*; (
	input  wire                   clk_sd,
	input  wire                   rst,
	input  wire                   dl_active,
	input  wire                   dl_wr,
	input  wire [DL_ADDR_W-1:0]   dl_addr,
	input  wire [7:0]             dl_data,
	input  wire                   prog_ack,
	input  wire                   gfx_ack,
	output logic                  prog_req,
	output logic                  gfx_req,
	output logic [WORD_ADDR_W-1:0] wr_word,
	output logic                  wr_lane,
	output logic [7:0]            wr_data,
	output logic                  dl_overrun
);

	logic     dl_wr_q;
	logic     cap_valid;
	dl_addr_u cap_addr;
	logic [7:0] cap_data;
	logic     wr_busy;
	logic     out_of_range;

	// A write is outstanding on either region port
	assign wr_busy      = (prog_req != prog_ack) || (gfx_req != gfx_ack);
	assign out_of_range = cap_addr.flat >= ROM_BYTES;

	// Capture stage for the strobe edge
	always_ff @(posedge clk_sd) begin
		if (rst) begin
			dl_wr_q   <= 1'b0;
			cap_valid <= 1'b0;
		end else begin
			dl_wr_q   <= dl_wr;
			cap_valid <= dl_active && dl_wr && !dl_wr_q;
		end
	end

	always_ff @(posedge clk_sd) begin
		if (dl_wr && !dl_wr_q) begin
			cap_addr.flat <= dl_addr;
			cap_data      <= dl_data;
		end
	end

	// Request stage, one write in flight at a time
	always_ff @(posedge clk_sd) begin
		if (rst) begin
			prog_req   <= 1'b0;
			gfx_req    <= 1'b0;
			dl_overrun <= 1'b0;
		end else if (cap_valid) begin
			if (wr_busy || out_of_range) begin
				dl_overrun <= 1'b1;
			end else if (cap_addr.fields.region == REGION_GFX) begin
				gfx_req <= ~gfx_req;
			end else begin
				prog_req <= ~prog_req;
			end
		end
	end

	// Fields stay put until the store acknowledges
	always_ff @(posedge clk_sd) begin
		if (cap_valid && !wr_busy && !out_of_range) begin
			wr_word <= cap_addr.fields.word;
			wr_lane <= cap_addr.fields.lane;
			wr_data <= cap_data;
		end
	end

endmodule

`default_nettype wire

// File: logic/rom_load_pkg.sv
`default_nettype none

package rom_load_pkg;

	// Download channel and memory geometry
	localparam int DL_ADDR_W   = 25;
	localparam int WORD_ADDR_W = 15;
	localparam int DATA_W      = 16;

	// First byte address past the graphics region
	localparam logic [DL_ADDR_W-1:0] ROM_BYTES = DL_ADDR_W'(2 * 2 * (1 << WORD_ADDR_W));

	// Access slot rotation, stands in for the 3:1 clock ratio
	localparam int SLOT_COUNT = 3;
	localparam int SLOT_W     = $clog2(SLOT_COUNT);

	localparam logic [SLOT_W-1:0] SLOT_WRITE = SLOT_W'(0);
	localparam logic [SLOT_W-1:0] SLOT_CPU   = SLOT_W'(1);
	localparam logic [SLOT_W-1:0] SLOT_GFX   = SLOT_W'(2);

	localparam logic REGION_PROGRAM = 1'b0;
	localparam logic REGION_GFX     = 1'b1;

	// Download byte address, as one number or split into its fields
	typedef union packed {
		logic [DL_ADDR_W-1:0] flat;
		struct packed {
			logic [DL_ADDR_W-WORD_ADDR_W-3:0] high;
			logic                             region;
			logic [WORD_ADDR_W-1:0]           word;
			logic                             lane;
		} fields;
	} dl_addr_u;

endpackage

`default_nettype wire

// File: logic/rom_loader_top.sv
`default_nettype none

module rom_loader_top import rom_load_pkg::*; (
	input  wire                    clk_sd,
	input  wire                    rst,
	input  wire                    dl_active,
	input  wire                    dl_wr,
	input  wire [DL_ADDR_W-1:0]    dl_addr,
	input  wire [7:0]              dl_data,
	input  wire                    status_reset,
	input  wire                    button_reset,
	input  wire [WORD_ADDR_W:0]    cpu_addr,
	input  wire [WORD_ADDR_W-1:0]  gfx_addr,
	output wire [7:0]              cpu_q,
	output wire [DATA_W-1:0]       gfx_q,
	output wire                    core_reset,
	output wire                    dl_overrun,
	output wire                    rom_loaded
);

	wire                   prog_req;
	wire                   gfx_req;
	wire                   prog_ack;
	wire                   gfx_ack;
	wire [WORD_ADDR_W-1:0] wr_word;
	wire                   wr_lane;
	wire [7:0]             wr_data;

	download_requester requester (
		.clk_sd     (clk_sd),
		.rst        (rst),
		.dl_active  (dl_active),
		.dl_wr      (dl_wr),
		.dl_addr    (dl_addr),
		.dl_data    (dl_data),
		.prog_ack   (prog_ack),
		.gfx_ack    (gfx_ack),
		.prog_req   (prog_req),
		.gfx_req    (gfx_req),
		.wr_word    (wr_word),
		.wr_lane    (wr_lane),
		.wr_data    (wr_data),
		.dl_overrun (dl_overrun)
	);

	boot_reset_ctrl reset_ctrl (
		.clk_sd       (clk_sd),
		.rst          (rst),
		.dl_active    (dl_active),
		.status_reset (status_reset),
		.button_reset (button_reset),
		.rom_loaded   (rom_loaded),
		.core_reset   (core_reset)
	);

	rom_store store (
		.clk_sd    (clk_sd),
		.rst       (rst),
		.dl_active (dl_active),
		.prog_req  (prog_req),
		.gfx_req   (gfx_req),
		.wr_word   (wr_word),
		.wr_lane   (wr_lane),
		.wr_data   (wr_data),
		.cpu_addr  (cpu_addr),
		.gfx_addr  (gfx_addr),
		.prog_ack  (prog_ack),
		.gfx_ack   (gfx_ack),
		.cpu_q     (cpu_q),
		.gfx_q     (gfx_q)
	);

endmodule

`default_nettype wire

// File: logic/rom_store.sv
`default_nettype none

module rom_store import rom_load_pkg::*; (
	input  wire                    clk_sd,
	input  wire                    rst,
	input  wire                    dl_active,
	input  wire                    prog_req,
	input  wire                    gfx_req,
	input  wire [WORD_ADDR_W-1:0]  wr_word,
	input  wire                    wr_lane,
	input  wire [7:0]              wr_data,
	input  wire [WORD_ADDR_W:0]    cpu_addr,
	input  wire [WORD_ADDR_W-1:0]  gfx_addr,
	output logic                   prog_ack,
	output logic                   gfx_ack,
	output logic [7:0]             cpu_q,
	output logic [DATA_W-1:0]      gfx_q
);

	localparam int DEPTH = 1 << WORD_ADDR_W;

	logic [DATA_W-1:0] prog_mem [0:DEPTH-1];
	logic [DATA_W-1:0] gfx_mem  [0:DEPTH-1];

	logic [SLOT_W-1:0] slot;
	logic              write_slot;
	logic              prog_wr_en;
	logic              gfx_wr_en;
	dl_addr_u          cpu_view;
	logic [DATA_W-1:0] cpu_word;

	// CPU byte address seen as a program region download address
	assign cpu_view = DL_ADDR_W'(cpu_addr);
	assign cpu_word = prog_mem[cpu_view.fields.word];

	assign write_slot = (slot == SLOT_WRITE);
	assign prog_wr_en = write_slot && (prog_req != prog_ack);
	// Program port wins if both were ever pending
	assign gfx_wr_en  = write_slot && (gfx_req != gfx_ack) && !prog_wr_en;

	always_ff @(posedge clk_sd) begin
		if (rst) begin
			slot <= SLOT_WRITE;
		end else if (slot == SLOT_W'(SLOT_COUNT - 1)) begin
			slot <= SLOT_WRITE;
		end else begin
			slot <= slot + 1'b1;
		end
	end

	// Ack toggles on the edge that writes the byte
	always_ff @(posedge clk_sd) begin
		if (rst) begin
			prog_ack <= 1'b0;
			gfx_ack  <= 1'b0;
		end else begin
			if (prog_wr_en) begin
				prog_ack <= prog_req;
			end
			if (gfx_wr_en) begin
				gfx_ack <= gfx_req;
			end
		end
	end

	// Byte lane writes
	always_ff @(posedge clk_sd) begin
		if (prog_wr_en) begin
			if (wr_lane) begin
				prog_mem[wr_word][15:8] <= wr_data;
			end else begin
				prog_mem[wr_word][7:0] <= wr_data;
			end
		end
	end

	always_ff @(posedge clk_sd) begin
		if (gfx_wr_en) begin
			if (wr_lane) begin
				gfx_mem[wr_word][15:8] <= wr_data;
			end else begin
				gfx_mem[wr_word][7:0] <= wr_data;
			end
		end
	end

	// Read slots; CPU side is frozen while a download runs
	always_ff @(posedge clk_sd) begin
		if (rst) begin
			cpu_q <= '0;
			gfx_q <= '0;
		end else begin
			if (slot == SLOT_CPU && !dl_active) begin
				cpu_q <= cpu_view.fields.lane ? cpu_word[15:8] : cpu_word[7:0];
			end
			if (slot == SLOT_GFX) begin
				gfx_q <= gfx_mem[gfx_addr];
			end
		end
	end

endmodule

`default_nettype wire

// File: tb.f
logic/rom_load_pkg.sv
logic/download_requester.sv
logic/boot_reset_ctrl.sv
logic/rom_store.sv
logic/rom_loader_top.sv
tb/rom_loader_tb.sv

// File: tb/rom_loader_tb.sv
`default_nettype none

module rom_loader_tb;

	localparam int MAX_REC = 96;

	logic        clk_sd = 1'b0;
	logic        rst;
	logic        dl_active;
	logic        dl_wr;
	logic [24:0] dl_addr;
	logic [7:0]  dl_data;
	logic        status_reset;
	logic        button_reset;
	logic [15:0] cpu_addr;
	logic [14:0] gfx_addr;
	wire  [7:0]  cpu_q;
	wire  [15:0] gfx_q;
	wire         core_reset;
	wire         dl_overrun;
	wire         rom_loaded;

	// Each record is four words of opcode, address, data byte and expected value
	logic [31:0] rec_mem [0:4*MAX_REC-1];
	int          cyc;
	int          mismatches = 0;
	int          timeouts = 0;
	int          other_errors = 0;

	rom_loader_top UUT (
		.clk_sd       (clk_sd),
		.rst          (rst),
		.dl_active    (dl_active),
		.dl_wr        (dl_wr),
		.dl_addr      (dl_addr),
		.dl_data      (dl_data),
		.status_reset (status_reset),
		.button_reset (button_reset),
		.cpu_addr     (cpu_addr),
		.gfx_addr     (gfx_addr),
		.cpu_q        (cpu_q),
		.gfx_q        (gfx_q),
		.core_reset   (core_reset),
		.dl_overrun   (dl_overrun),
		.rom_loaded   (rom_loaded)
	);

	always #4 clk_sd = ~clk_sd;

	// Cycles since reset that track the store's slot modulo 3
	always @(posedge clk_sd) begin
		if (rst) begin
			cyc <= 0;
		end else begin
			cyc <= cyc + 1;
		end
	end

	function automatic logic flag_value(input logic [31:0] sel);
		case (sel)
			32'd0: return core_reset;
			32'd1: return rom_loaded;
			default: return dl_overrun;
		endcase
	endfunction

	function automatic string flag_name(input logic [31:0] sel);
		case (sel)
			32'd0: return "core_reset";
			32'd1: return "rom_loaded";
			default: return "dl_overrun";
		endcase
	endfunction

	task automatic send_byte(input logic [24:0] addr, input logic [7:0] data, input int gap);
		@(posedge clk_sd);
		dl_addr <= addr;
		dl_data <= data;
		dl_wr   <= 1'b1;
		@(posedge clk_sd);
		dl_wr <= 1'b0;
		repeat (gap) @(posedge clk_sd);
	endtask

	// Next byte then starts where its write is still pending two cycles later
	task automatic align_phase();
		int tries;
		tries = 0;
		@(posedge clk_sd);
		while (cyc % 3 != 0 && tries < 6) begin
			@(posedge clk_sd);
			tries++;
		end
		if (cyc % 3 != 0) begin
			$display("timeout waiting for the write slot phase");
			timeouts++;
		end
	endtask

	// Slowest flag path is two registers deep
	task automatic check_flag(input logic [31:0] sel, input logic expected, input int idx);
		repeat (3) @(posedge clk_sd);
		if (flag_value(sel) !== expected) begin
			$display("mismatch %s check (record %0d): expected %b, actual %b",
				flag_name(sel), idx, expected, flag_value(sel));
			mismatches++;
		end
	endtask

	initial begin
		int          idx;
		bit          done;
		logic [31:0] op;
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] expv;
		rst          = 1'b1;
		dl_active    = 1'b0;
		dl_wr        = 1'b0;
		dl_addr      = '0;
		dl_data      = '0;
		status_reset = 1'b0;
		button_reset = 1'b0;
		cpu_addr     = '0;
		gfx_addr     = '0;
		$readmemh("tb/rom_loader_testdata.txt", rec_mem);
		repeat (2) @(posedge clk_sd);
		rst <= 1'b0;
		idx  = 0;
		done = 1'b0;
		while (!done && idx < MAX_REC) begin
			op   = rec_mem[4*idx];
			addr = rec_mem[4*idx+1];
			data = rec_mem[4*idx+2];
			expv = rec_mem[4*idx+3];
			case (op)
				32'h0: done = 1'b1;
				32'h1: begin
					@(posedge clk_sd);
					dl_active <= 1'b1;
				end
				32'h2: begin
					@(posedge clk_sd);
					dl_active <= 1'b0;
				end
				32'h3: send_byte(addr[24:0], data[7:0], 6);
				32'h4: begin
					@(posedge clk_sd);
					cpu_addr <= addr[15:0];
					repeat (6) @(posedge clk_sd);
					if (cpu_q !== expv[7:0]) begin
						$display("mismatch cpu read %h (record %0d): expected %h, actual %h",
							addr[15:0], idx, expv[7:0], cpu_q);
						mismatches++;
					end
				end
				32'h5: begin
					@(posedge clk_sd);
					gfx_addr <= addr[14:0];
					repeat (6) @(posedge clk_sd);
					if (gfx_q !== expv[15:0]) begin
						$display("mismatch gfx read %h (record %0d): expected %h, actual %h",
							addr[14:0], idx, expv[15:0], gfx_q);
						mismatches++;
					end
				end
				32'h6: begin
					@(posedge clk_sd);
					status_reset <= data[0];
					button_reset <= data[1];
				end
				32'h7: check_flag(addr, expv[0], idx);
				32'h8: begin
					align_phase();
					send_byte(addr[24:0], data[7:0], 0);
				end
				32'h9: begin
					@(posedge clk_sd);
					rst <= 1'b1;
					repeat (2) @(posedge clk_sd);
					rst <= 1'b0;
				end
				default: begin
					$display("record %0d has no valid opcode, test data is missing or broken", idx);
					other_errors++;
					done = 1'b1;
				end
			endcase
			idx++;
		end
		$display("errors: %0d mismatches, %0d timeouts, %0d other", mismatches, timeouts,
			other_errors);
		if (mismatches + timeouts + other_errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tb/rom_loader_testdata.txt
// Columns: opcode, address, data byte, expected value (hex)
// Opcodes: 1/2 begin/end download, 3 byte, 4 cpu read, 5 gfx read, 6 reset sources,
// 7 flag (0 core_reset, 1 rom_loaded, 2 dl_overrun), 8 byte on write phase, 9 rst, 0 end
07 00000000 00 0001
07 00000001 00 0000
01 00000000 00 0000
03 00000000 11 0000
03 00000001 22 0000
03 00000002 33 0000
03 00001235 5a 0000
03 0000ffff c3 0000
03 00010000 34 0000
03 00010001 12 0000
03 00010002 cd 0000
03 00010003 ab 0000
03 0001fffe 0f 0000
03 0001ffff f0 0000
02 00000000 00 0000
07 00000001 00 0001
07 00000000 00 0000
07 00000002 00 0000
04 00000000 00 0011
04 00000001 00 0022
04 00000002 00 0033
04 00001235 00 005a
04 0000ffff 00 00c3
05 00000000 00 1234
05 00000001 00 abcd
05 00007fff 00 f00f
06 00000000 01 0000
07 00000000 00 0001
06 00000000 00 0000
07 00000000 00 0000
06 00000000 02 0000
07 00000000 00 0001
06 00000000 00 0000
07 00000000 00 0000
// High byte rewrites, then a second byte while the first is still pending
01 00000000 00 0000
03 00000001 99 0000
03 00010003 5e 0000
08 00000004 44 0000
03 00000002 77 0000
02 00000000 00 0000
07 00000002 00 0001
04 00000000 00 0011
04 00000001 00 0099
05 00000001 00 5ecd
04 00000002 00 0033
04 00000004 00 0044
// Out of range byte after a fresh reset
09 00000000 00 0000
07 00000002 00 0000
07 00000001 00 0000
07 00000000 00 0001
01 00000000 00 0000
03 00020000 ee 0000
02 00000000 00 0000
07 00000002 00 0001
04 00000000 00 0011
05 00000000 00 1234
00 00000000 00 0000
